//--- hdl/rename_pkg.sv
// register file sizes, RAT and free pool reset mapping, micro-op opcode classes
package rename_pkg;

    localparam int phys_regs = 16;
    localparam int pr_addr_w = 4;
    localparam int arch_regs = 10;
    localparam int pool_w = phys_regs - 2;           // bit k of the pool is physical register k+2
    localparam int rat_w = pr_addr_w * arch_regs;

    localparam logic [3:0] reg_pch = 4'd9;
    localparam logic [3:0] reg_pcl = 4'd8;

    // opcode lives in microop[23:20], anything not listed is a two destination op
    typedef enum logic [3:0] {
        op_load   = 4'hC,
        op_store  = 4'hD,
        op_term_a = 4'hE,
        op_term_b = 4'hF
    } op_class_e;

    // after reset each architectural register maps onto the physical register of the same number
    function automatic logic [rat_w-1:0] rat_identity();
        logic [rat_w-1:0] map;
        map = '0;
        for (int i = 0; i < arch_regs; i++) begin
            map[i * pr_addr_w +: pr_addr_w] = pr_addr_w'(i);
        end
        return map;
    endfunction

    localparam logic [rat_w-1:0] rat_reset = rat_identity();

    // physical registers arch_regs and up start out free
    localparam logic [pool_w-1:0] pool_reset = {pool_w{1'b1}} << (arch_regs - 2);

endpackage

//--- hdl/free_reg_picker.sv
// priority encoder returning the lowest set bit of the free pool
`timescale 1ns/10ps

module free_reg_picker (
    input  logic [rename_pkg::pool_w-1:0]    pool,
    output logic                             any,
    output logic [rename_pkg::pr_addr_w-1:0] index
);

    assign any = |pool;

    // scan from the top so the lowest set bit is the last one written
    always_comb begin
        index = '0;
        for (int k = rename_pkg::pool_w - 1; k >= 0; k--) begin
            if (pool[k]) begin
                index = rename_pkg::pr_addr_w'(k);
            end
        end
    end

endmodule

//--- hdl/rename_cell.sv
// one rename step, allocates a free physical register for a single destination
`timescale 1ns/10ps

module rename_cell (
    input  logic [3:0]                       arch_reg,
    input  logic [rename_pkg::pool_w-1:0]    free_pool,
    input  logic [rename_pkg::rat_w-1:0]     rat_aliases,
    output logic [rename_pkg::pool_w-1:0]    new_free_pool,
    output logic [rename_pkg::rat_w-1:0]     new_rat_aliases,
    output logic [rename_pkg::pr_addr_w-1:0] phys_reg,
    output logic [rename_pkg::pr_addr_w-1:0] old_reg,
    output logic                             phys_reg_valid
);

    logic                             pick_any;
    logic [rename_pkg::pr_addr_w-1:0] pick_index;
    logic                             does_rename;

    free_reg_picker u_picker (
        .pool  (free_pool),
        .any   (pick_any),
        .index (pick_index)
    );

    // 0 and 1 are hard-wired, 10 and up are not architectural registers at all
    assign does_rename = (arch_reg >= 4'd2) && (arch_reg < 4'(rename_pkg::arch_regs));

    assign phys_reg_valid = !does_rename || pick_any;

    always_comb begin
        new_free_pool = free_pool;
        new_rat_aliases = rat_aliases;
        if (does_rename) begin
            phys_reg = pick_index + 4'd2;            // pool bit 0 is physical register 2
            old_reg = rat_aliases[arch_reg * rename_pkg::pr_addr_w +: rename_pkg::pr_addr_w];
            new_free_pool[pick_index] = 1'b0;
            new_rat_aliases[arch_reg * rename_pkg::pr_addr_w +: rename_pkg::pr_addr_w] = phys_reg;
        end else begin
            phys_reg = (arch_reg < 4'd2) ? arch_reg : '0;
            old_reg = phys_reg;
        end
    end

endmodule

//--- hdl/renamer.sv
// destination decode and two chained rename cells with all-or-nothing commit
`timescale 1ns/10ps

module renamer (
    input  logic                               microop_valid,
    input  logic [23:0]                        microop,
    input  logic [rename_pkg::pool_w-1:0]      free_pool,
    input  logic [rename_pkg::rat_w-1:0]       rat_aliases,
    output logic [rename_pkg::pool_w-1:0]      new_free_pool,
    output logic [rename_pkg::rat_w-1:0]       new_rat_aliases,
    output logic                               commit,
    output logic [7:0]                         dst_arch_regs,
    output logic [2*rename_pkg::pr_addr_w-1:0] dst_regs,
    output logic [2*rename_pkg::pr_addr_w-1:0] old_regs
);

    localparam int aw = rename_pkg::pr_addr_w;

    rename_pkg::op_class_e opcode;

    logic [rename_pkg::pool_w-1:0] pool_carry;
    logic [rename_pkg::pool_w-1:0] pool_done;
    logic [rename_pkg::rat_w-1:0]  rat_carry;
    logic [rename_pkg::rat_w-1:0]  rat_done;
    logic                          lo_valid;
    logic                          hi_valid;

    assign opcode = rename_pkg::op_class_e'(microop[23:20]);

    always_comb begin
        case (opcode)
            rename_pkg::op_load:   dst_arch_regs = {4'h0, microop[15:12]};
            rename_pkg::op_store:  dst_arch_regs = 8'h00;
            rename_pkg::op_term_a,
            rename_pkg::op_term_b: dst_arch_regs = {rename_pkg::reg_pch, rename_pkg::reg_pcl};
            default:               dst_arch_regs = microop[19:12];
        endcase
    end

    // low field goes first, the high field sees the pool and RAT it leaves behind
    rename_cell u_cell_lo (
        .arch_reg        (dst_arch_regs[3:0]),
        .free_pool       (free_pool),
        .rat_aliases     (rat_aliases),
        .new_free_pool   (pool_carry),
        .new_rat_aliases (rat_carry),
        .phys_reg        (dst_regs[aw-1:0]),
        .old_reg         (old_regs[aw-1:0]),
        .phys_reg_valid  (lo_valid)
    );

    rename_cell u_cell_hi (
        .arch_reg        (dst_arch_regs[7:4]),
        .free_pool       (pool_carry),
        .rat_aliases     (rat_carry),
        .new_free_pool   (pool_done),
        .new_rat_aliases (rat_done),
        .phys_reg        (dst_regs[2*aw-1:aw]),
        .old_reg         (old_regs[2*aw-1:aw]),
        .phys_reg_valid  (hi_valid)
    );

    assign commit = microop_valid && lo_valid && hi_valid;

    assign new_free_pool = commit ? pool_done : free_pool;    // a half-renamed op leaves no trace
    assign new_rat_aliases = commit ? rat_done : rat_aliases;

endmodule

//--- hdl/rename_state.sv
// RAT and free pool registers with reset mapping and the retire-free path
`timescale 1ns/10ps

module rename_state (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             commit,
    input  logic [rename_pkg::pool_w-1:0]    new_free_pool,
    input  logic [rename_pkg::rat_w-1:0]     new_rat_aliases,
    input  logic                             free_valid,
    input  logic [rename_pkg::pr_addr_w-1:0] free_reg,
    output logic [rename_pkg::pool_w-1:0]    free_pool,
    output logic [rename_pkg::rat_w-1:0]     rat_aliases
);

    logic [rename_pkg::pool_w-1:0] freed_bit;
    logic [rename_pkg::pool_w-1:0] pool_next;
    logic [rename_pkg::rat_w-1:0]  rat_next;

    // retiring 0 or 1 would put a hard-wired register into the pool, drop it
    always_comb begin
        freed_bit = '0;
        if (free_valid && (free_reg >= 4'd2)) begin
            freed_bit[free_reg - 4'd2] = 1'b1;
        end
    end

    always_comb begin
        if (commit) begin
            pool_next = new_free_pool;
            rat_next = new_rat_aliases;
        end else begin
            pool_next = free_pool;
            rat_next = rat_aliases;
        end
        pool_next = pool_next | freed_bit;            // freed register shows up next cycle
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            free_pool <= rename_pkg::pool_reset;
            rat_aliases <= rename_pkg::rat_reset;
        end else begin
            free_pool <= pool_next;
            rat_aliases <= rat_next;
        end
    end

endmodule

//--- hdl/rename_top.sv
// rename stage top level joining the combinational renamer and its state
`timescale 1ns/10ps

module rename_top (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               microop_valid,
    input  logic [23:0]                        microop,
    input  logic                               free_valid,
    input  logic [rename_pkg::pr_addr_w-1:0]   free_reg,
    output logic                               rename_valid,
    output logic [7:0]                         dst_arch_regs,
    output logic [2*rename_pkg::pr_addr_w-1:0] dst_regs,
    output logic [2*rename_pkg::pr_addr_w-1:0] old_regs
);

    logic [rename_pkg::pool_w-1:0] free_pool;
    logic [rename_pkg::rat_w-1:0]  rat_aliases;
    logic [rename_pkg::pool_w-1:0] new_free_pool;
    logic [rename_pkg::rat_w-1:0]  new_rat_aliases;
    logic                          commit;

    assign rename_valid = commit;

    renamer u_renamer (
        .microop_valid   (microop_valid),
        .microop         (microop),
        .free_pool       (free_pool),
        .rat_aliases     (rat_aliases),
        .new_free_pool   (new_free_pool),
        .new_rat_aliases (new_rat_aliases),
        .commit          (commit),
        .dst_arch_regs   (dst_arch_regs),
        .dst_regs        (dst_regs),
        .old_regs        (old_regs)
    );

    rename_state u_rename_state (
        .clk             (clk),
        .arst_n          (arst_n),
        .commit          (commit),
        .new_free_pool   (new_free_pool),
        .new_rat_aliases (new_rat_aliases),
        .free_valid      (free_valid),
        .free_reg        (free_reg),
        .free_pool       (free_pool),
        .rat_aliases     (rat_aliases)
    );

endmodule

//--- test/tb_clock_gen.sv
// free running testbench clock with a 20 ns period
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk
);

    localparam int half_period = 10;

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

//--- test/tb_rename_top.sv
// rename stage testbench with reference model, checker, directed tests and a random mix
`timescale 1ns/10ps

module tb_rename_top;

    localparam int rename_limit = 20;
    localparam int drain_limit = 40;

    logic        clk;
    logic        arst_n;
    logic        microop_valid;
    logic [23:0] microop;
    logic        free_valid;
    logic [3:0]  free_reg;
    logic        rename_valid;
    logic [7:0]  dst_arch_regs;
    logic [7:0]  dst_regs;
    logic [7:0]  old_regs;

    logic [3:0]  ref_rat [0:9];
    logic [15:0] ref_free;                        // indexed by physical register number
    logic [3:0]  nxt_rat [0:9];
    logic [15:0] nxt_free;
    logic        exp_valid;
    logic [7:0]  exp_arch;
    logic [7:0]  exp_dst;
    logic [7:0]  exp_old;

    int         checks;
    int         errors;
    int         tests;
    int         test_checks;
    int         test_errors;
    int         cycle;
    integer     seed;
    int         due_q [$];
    logic [3:0] reg_q [$];

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    rename_top u_rename_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .microop_valid (microop_valid),
        .microop       (microop),
        .free_valid    (free_valid),
        .free_reg      (free_reg),
        .rename_valid  (rename_valid),
        .dst_arch_regs (dst_arch_regs),
        .dst_regs      (dst_regs),
        .old_regs      (old_regs)
    );

    function automatic logic [23:0] make_op(input logic [3:0] opc, input logic [3:0] hi,
                                            input logic [3:0] lo);
        return {opc, hi, lo, 12'h3c7};
    endfunction

    task automatic reset_reference();
        for (int i = 0; i < 10; i++) begin
            ref_rat[i] = 4'(i);
        end
        ref_free = 16'hfc00;                      // physical 10 to 15 start out free
    endtask

    // expected outputs and next state, low destination first and lowest free register first
    function automatic void predict_rename(input logic [23:0] op);
        logic [3:0] fld [0:1];
        logic [3:0] pick;
        logic       found;
        case (op[23:20])
            4'hC: begin
                fld[1] = 4'd0;
                fld[0] = op[15:12];
            end
            4'hD: begin
                fld[1] = 4'd0;
                fld[0] = 4'd0;
            end
            4'hE, 4'hF: begin
                fld[1] = 4'd9;
                fld[0] = 4'd8;
            end
            default: begin
                fld[1] = op[19:16];
                fld[0] = op[15:12];
            end
        endcase
        nxt_rat = ref_rat;
        nxt_free = ref_free;
        exp_valid = 1'b1;
        exp_arch = {fld[1], fld[0]};
        for (int s = 0; s < 2; s++) begin
            if (fld[s] >= 4'd2 && fld[s] <= 4'd9) begin
                pick = 4'd0;
                found = 1'b0;
                for (int p = 15; p >= 2; p--) begin
                    if (nxt_free[p]) begin
                        pick = 4'(p);
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    exp_valid = 1'b0;
                end
                exp_dst[s*4 +: 4] = pick;
                exp_old[s*4 +: 4] = nxt_rat[fld[s]];
                nxt_free[pick] = 1'b0;
                nxt_rat[fld[s]] = pick;
            end else begin
                exp_dst[s*4 +: 4] = (fld[s] < 4'd2) ? fld[s] : 4'd0;
                exp_old[s*4 +: 4] = exp_dst[s*4 +: 4];
            end
        end
    endfunction

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // outputs are settled at the falling edge, state moves on the following rising edge
    always @(negedge clk) begin
        if (!arst_n) begin
            reset_reference();
        end else begin
            if (microop_valid) begin
                predict_rename(microop);
                compare("rename_valid", {7'h0, rename_valid}, {7'h0, exp_valid});
                compare("dst_arch_regs", dst_arch_regs, exp_arch);
                if (exp_valid) begin
                    compare("dst_regs", dst_regs, exp_dst);
                    compare("old_regs", old_regs, exp_old);
                    ref_rat = nxt_rat;
                    ref_free = nxt_free;
                end
            end
            if (free_valid && free_reg >= 4'd2) begin
                ref_free[free_reg] = 1'b1;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
        cycle++;
    endtask

    task automatic apply_reset();
        microop_valid = 1'b0;
        free_valid = 1'b0;
        arst_n = 1'b0;
        repeat (8) next_cycle();
        arst_n = 1'b1;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("*** FAILED ***");
        $finish;
    endtask

    // the micro-op is already on the inputs, hold it until it is renamed
    task automatic await_rename();
        int waited;
        waited = 0;
        @(negedge clk);
        while (rename_valid !== 1'b1) begin
            waited++;
            if (waited > rename_limit) begin
                report_timeout("rename_valid never rose for a held micro-op");
            end
            @(negedge clk);
        end
        next_cycle();
        microop_valid = 1'b0;
    endtask

    task automatic send_op(input logic [23:0] op);
        microop_valid = 1'b1;
        microop = op;
        await_rename();
    endtask

    task automatic hold_op(input logic [23:0] op, input int cycles);
        microop_valid = 1'b1;
        microop = op;
        repeat (cycles) next_cycle();
        microop_valid = 1'b0;
    endtask

    task automatic drain_pool();
        send_op(make_op(4'h0, 4'h3, 4'h2));
        send_op(make_op(4'h0, 4'h5, 4'h4));
        send_op(make_op(4'h0, 4'h7, 4'h6));
    endtask

    task automatic queue_retire(input logic [7:0] olds);
        int delay;
        for (int s = 0; s < 2; s++) begin
            if (olds[s*4 +: 4] >= 4'd2) begin
                delay = int'($unsigned($random(seed)) % 32'd4);
                due_q.push_back(cycle + 1 + delay);
                reg_q.push_back(olds[s*4 +: 4]);
            end
        end
    endtask

    task automatic drive_retire();
        int pick;
        pick = -1;
        for (int i = 0; i < due_q.size(); i++) begin
            if (pick < 0 && due_q[i] <= cycle) begin
                pick = i;
            end
        end
        free_valid = (pick >= 0);
        if (pick >= 0) begin
            free_reg = reg_q[pick];
            due_q.delete(pick);
            reg_q.delete(pick);
        end
    endtask

    task automatic random_mix();
        int waited;
        for (int n = 0; n < 300; n++) begin
            microop_valid = 1'b1;
            microop = 24'($random(seed));
            waited = 0;
            drive_retire();
            @(negedge clk);
            while (rename_valid !== 1'b1) begin
                waited++;
                if (waited > rename_limit) begin
                    report_timeout("random micro-op stalled with no register coming back");
                end
                next_cycle();
                drive_retire();
                @(negedge clk);
            end
            queue_retire(old_regs);
            next_cycle();
        end
        microop_valid = 1'b0;
        waited = 0;
        while (due_q.size() > 0) begin
            waited++;
            if (waited > drain_limit) begin
                report_timeout("retire queue did not empty");
            end
            drive_retire();
            next_cycle();
        end
        free_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    initial begin
        seed = 19809;
        arst_n = 1'b0;
        microop_valid = 1'b0;
        microop = 24'h0;
        free_valid = 1'b0;
        free_reg = 4'd0;
        checks = 0;
        errors = 0;
        tests = 0;
        test_checks = 0;
        test_errors = 0;
        cycle = 0;

        apply_reset();
        send_op(make_op(4'hC, 4'h0, 4'h2));
        send_op(make_op(4'h1, 4'h4, 4'h3));
        finish_test("reset mapping");

        apply_reset();
        send_op(make_op(4'h2, 4'h5, 4'h5));
        finish_test("same register twice");

        apply_reset();
        send_op(make_op(4'hD, 4'h6, 4'h7));      // store fields name nothing
        send_op(make_op(4'h3, 4'h1, 4'h0));
        send_op(make_op(4'h4, 4'hf, 4'ha));
        send_op(make_op(4'hC, 4'h3, 4'hc));
        send_op(make_op(4'hE, 4'h2, 4'h3));      // terminate always renames 9 and 8
        finish_test("no-rename classes");

        apply_reset();
        drain_pool();
        hold_op(make_op(4'h0, 4'h9, 4'h8), 3);
        free_valid = 1'b1;
        free_reg = 4'd2;
        next_cycle();
        free_valid = 1'b0;
        send_op(make_op(4'hC, 4'h0, 4'h8));      // old alias of 8 must still be 8
        finish_test("exhaustion");

        apply_reset();
        drain_pool();
        microop_valid = 1'b1;
        microop = make_op(4'h0, 4'h9, 4'h8);
        free_valid = 1'b1;
        free_reg = 4'd0;
        next_cycle();
        free_reg = 4'd1;
        next_cycle();
        free_reg = 4'd5;
        next_cycle();
        free_reg = 4'd3;
        next_cycle();
        free_valid = 1'b0;
        await_rename();
        finish_test("free and reuse");

        apply_reset();
        random_mix();
        finish_test("random mix");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- compile.f
hdl/rename_pkg.sv
hdl/free_reg_picker.sv
hdl/rename_cell.sv
hdl/renamer.sv
hdl/rename_state.sv
hdl/rename_top.sv
test/tb_clock_gen.sv
test/tb_rename_top.sv

//--- run.sh
#!/bin/sh
# builds the rename stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module tb_rename_top -o tb_rename_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_rename_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q -x -F '*** PASSED ***'; then
    exit 0
fi
exit 1
